// File: include/cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

//////////////////////////////////////////////////////////////////////
// cache geometry
//////////////////////////////////////////////////////////////////////

// word select bits inside one block
`define CACHE_OFFSET_WIDTH 3

// set select bits, 64 sets per way
`define CACHE_INDEX_WIDTH 6

// whatever is left of a 30-bit word address
`define CACHE_TAG_WIDTH 21

// words in one block
`define CACHE_WORDS_PER_BLOCK 8

// data word
`define CACHE_WORD_WIDTH 32

`endif

// File: logic/cache_pkg.sv
`include "cache_macros.svh"

package cache_pkg;

    //////////////////////////////////////////////////////////////////////
    // address decoding
    //////////////////////////////////////////////////////////////////////

    // word address split into its cache fields
    typedef struct packed {
        logic [`CACHE_TAG_WIDTH-1:0]    tag;
        logic [`CACHE_INDEX_WIDTH-1:0]  index;
        logic [`CACHE_OFFSET_WIDTH-1:0] word_sel;
    } cache_addr_fields_t;

    // same 30 bits seen as a flat word address or as fields
    typedef union packed {
        logic [`CACHE_TAG_WIDTH+`CACHE_INDEX_WIDTH+`CACHE_OFFSET_WIDTH-1:0] raw;
        cache_addr_fields_t                                                 fields;
    } cache_addr_u;

    //////////////////////////////////////////////////////////////////////
    // data block
    //////////////////////////////////////////////////////////////////////

    // one cache block, word 0 in the low bits
    typedef logic [`CACHE_WORDS_PER_BLOCK-1:0][`CACHE_WORD_WIDTH-1:0] cache_block_t;

    //////////////////////////////////////////////////////////////////////
    // per-way status
    //////////////////////////////////////////////////////////////////////

    // what one way reports about the addressed set
    // hit is the raw tag match, the top qualifies it with valid
    typedef struct packed {
        logic                        hit;
        logic                        valid;
        logic                        dirty;
        logic [`CACHE_TAG_WIDTH-1:0] tag;
    } way_status_t;

endpackage

// File: logic/cache_oneline.sv
`include "cache_macros.svh"

module cache_oneline (
    input  logic                           clk,
    input  logic                           arst_n,

    // control
    input  logic                           enable,
    input  logic                           cmp,
    input  logic                           write,
    input  logic [3:0]                     byte_w_en,

    // address and data
    input  logic                           valid_in,
    input  logic [`CACHE_TAG_WIDTH-1:0]    tag_in,
    input  logic [`CACHE_INDEX_WIDTH-1:0]  index,
    input  logic [`CACHE_OFFSET_WIDTH-1:0] word_sel,
    input  logic [`CACHE_WORD_WIDTH-1:0]   data_in,
    input  cache_pkg::cache_block_t        data_block_in,

    // lookup results
    output cache_pkg::way_status_t         status,
    output logic [`CACHE_WORD_WIDTH-1:0]   data_out,
    output cache_pkg::cache_block_t        data_wb
);

    import cache_pkg::*;

    localparam int unsigned SETS = 1 << `CACHE_INDEX_WIDTH;

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // control bits per set
    logic [SETS-1:0] valid_q;
    logic [SETS-1:0] dirty_q;

    // payload arrays
    logic [`CACHE_TAG_WIDTH-1:0] tag_mem   [SETS];
    cache_block_t                block_mem [SETS];

    // addressed set
    logic [`CACHE_TAG_WIDTH-1:0]  cur_tag;
    cache_block_t                 cur_block;
    logic [`CACHE_WORD_WIDTH-1:0] cur_word;

    // write path
    logic                         wr_en;
    logic [`CACHE_WORD_WIDTH-1:0] merged_word;

    //////////////////////////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////////////////////////

    assign cur_tag   = tag_mem[index];
    assign cur_block = block_mem[index];
    assign cur_word  = cur_block[word_sel];

    // raw tag match, valid stays a separate field
    assign status.hit   = (cur_tag == tag_in);
    assign status.valid = valid_q[index];
    assign status.dirty = dirty_q[index];
    assign status.tag   = cur_tag;

    assign data_out = cur_word;
    assign data_wb  = cur_block;

    //////////////////////////////////////////////////////////////////////
    // write
    //////////////////////////////////////////////////////////////////////

    // the way only stores when the top enables it
    assign wr_en = enable & write;

    // byte merge into the selected word
    always_comb begin
        merged_word = cur_word;
        for (int b = 0; b < `CACHE_WORD_WIDTH / 8; b++) begin
            if (byte_w_en[b]) begin
                merged_word[8*b +: 8] = data_in[8*b +: 8];
            end
        end
    end

    // valid and dirty
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (wr_en) begin
            if (cmp) begin
                // store hit, the set now differs from memory
                dirty_q[index] <= 1'b1;
            end else begin
                // fresh block from memory is clean
                valid_q[index] <= valid_in;
                dirty_q[index] <= 1'b0;
            end
        end
    end

    // tags and blocks
    always_ff @(posedge clk) begin
        if (wr_en) begin
            if (cmp) begin
                block_mem[index][word_sel] <= merged_word;
            end else begin
                block_mem[index] <= data_block_in;
                tag_mem[index]   <= tag_in;
            end
        end
    end

endmodule

// File: logic/victimway_sel.sv
module victimway_sel (
    input  logic                   clk,
    input  logic                   arst_n,

    // access qualifiers
    input  logic                   enable,
    input  logic                   cmp,

    // state of the addressed set in each way
    input  cache_pkg::way_status_t way0,
    input  cache_pkg::way_status_t way1,

    // way to replace on the next load
    output logic                   victim_q
);

    logic victim_next;

    //////////////////////////////////////////////////////////////////////
    // replacement choice
    //////////////////////////////////////////////////////////////////////

    // empty ways first, then clean ones
    // both dirty means alternate so write-backs spread over the two ways
    always_comb begin
        if (!way0.valid) begin
            victim_next = 1'b0;
        end else if (!way1.valid) begin
            victim_next = 1'b1;
        end else if (!way0.dirty) begin
            victim_next = 1'b0;
        end else if (!way1.dirty) begin
            victim_next = 1'b1;
        end else begin
            victim_next = ~victim_q;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // registered victim
    //////////////////////////////////////////////////////////////////////

    // only a live compare looks at the set, loads keep the choice
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            victim_q <= 1'b0;
        end else if (enable && cmp) begin
            victim_q <= victim_next;
        end
    end

endmodule

// File: logic/cache_2ways.sv
`include "cache_macros.svh"

module cache_2ways (
    input  logic                         clk,
    input  logic                         arst_n,

    // control
    input  logic                         enable,
    input  logic                         cmp,
    input  logic                         write,
    input  logic [3:0]                   byte_w_en,

    // address and data in
    input  logic                         valid_in,
    input  cache_pkg::cache_addr_u       addr,
    input  logic [`CACHE_WORD_WIDTH-1:0] data_in,
    input  cache_pkg::cache_block_t      data_block_in,

    // lookup results
    output logic                         hit,
    output logic                         dirty,
    output logic                         valid_out,
    output logic [`CACHE_TAG_WIDTH-1:0]  tag_out,
    output logic [`CACHE_WORD_WIDTH-1:0] data_out,
    output cache_pkg::cache_block_t      data_wb
);

    import cache_pkg::*;

    // decoded address
    cache_addr_fields_t addr_f;

    // per-way status and data
    way_status_t                  way0_st;
    way_status_t                  way1_st;
    logic [`CACHE_WORD_WIDTH-1:0] way0_word;
    logic [`CACHE_WORD_WIDTH-1:0] way1_word;
    cache_block_t                 way0_block;
    cache_block_t                 way1_block;

    // per-way controls
    logic way0_en;
    logic way1_en;
    logic way0_wr;
    logic way1_wr;
    logic way0_hit_v;
    logic way1_hit_v;

    logic victim_q;

    assign addr_f = addr.fields;

    //////////////////////////////////////////////////////////////////////
    // way control
    //////////////////////////////////////////////////////////////////////

    assign way0_hit_v = way0_st.valid & way0_st.hit;
    assign way1_hit_v = way1_st.valid & way1_st.hit;

    // compare looks at both ways, a load touches only the victim
    assign way0_en = cmp ? enable : ~victim_q;
    assign way1_en = cmp ? enable : victim_q;

    // store hits go to the hitting way, loads to the victim
    // so at most one strobe is high
    assign way0_wr = write & (cmp ? (way0_hit_v & enable) : ~victim_q);
    assign way1_wr = write & (cmp ? (way1_hit_v & enable) : victim_q);

    //////////////////////////////////////////////////////////////////////
    // ways and victim selection
    //////////////////////////////////////////////////////////////////////

    victimway_sel victim_sel_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .enable   (enable),
        .cmp      (cmp),
        .way0     (way0_st),
        .way1     (way1_st),
        .victim_q (victim_q)
    );

    cache_oneline way0_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .enable        (way0_en),
        .cmp           (cmp),
        .write         (way0_wr),
        .byte_w_en     (byte_w_en),
        .valid_in      (valid_in),
        .tag_in        (addr_f.tag),
        .index         (addr_f.index),
        .word_sel      (addr_f.word_sel),
        .data_in       (data_in),
        .data_block_in (data_block_in),
        .status        (way0_st),
        .data_out      (way0_word),
        .data_wb       (way0_block)
    );

    cache_oneline way1_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .enable        (way1_en),
        .cmp           (cmp),
        .write         (way1_wr),
        .byte_w_en     (byte_w_en),
        .valid_in      (valid_in),
        .tag_in        (addr_f.tag),
        .index         (addr_f.index),
        .word_sel      (addr_f.word_sel),
        .data_in       (data_in),
        .data_block_in (data_block_in),
        .status        (way1_st),
        .data_out      (way1_word),
        .data_wb       (way1_block)
    );

    //////////////////////////////////////////////////////////////////////
    // output muxing
    //////////////////////////////////////////////////////////////////////

    // a hit in either way
    assign hit       = (way0_hit_v | way1_hit_v) & enable;
    assign valid_out = (way0_st.valid | way1_st.valid) & enable;

    // write-back is only needed once no clean way is left in the set
    assign dirty = way0_st.dirty & way1_st.dirty;

    // way 1 by default when way 0 misses
    assign data_out = way0_hit_v ? way0_word : way1_word;

    // victim tag and block for write-back, zero on compares
    assign tag_out = cmp ? '0 : (victim_q ? way1_st.tag : way0_st.tag);
    assign data_wb = cmp ? '0 : (victim_q ? way1_block : way0_block);

endmodule

// File: verification/cache_2ways_assertions.sv
`include "cache_macros.svh"

module cache_2ways_assertions (
    input logic                         clk,
    input logic                         arst_n,
    input logic                         enable,
    input logic                         cmp,
    input logic                         write,
    input logic [3:0]                   byte_w_en,
    input logic                         valid_in,
    input cache_pkg::cache_addr_u       addr,
    input logic [`CACHE_WORD_WIDTH-1:0] data_in,
    input cache_pkg::cache_block_t      data_block_in,
    input logic                         hit,
    input logic                         dirty,
    input logic                         valid_out,
    input logic [`CACHE_TAG_WIDTH-1:0]  tag_out,
    input logic [`CACHE_WORD_WIDTH-1:0] data_out,
    input cache_pkg::cache_block_t      data_wb
);

    timeunit 1ns;
    timeprecision 1ps;

    import cache_pkg::*;

    localparam int SETS = 1 << `CACHE_INDEX_WIDTH;

    // raised by any failing assertion
    bit assert_fail;

    // shadow of both ways
    // known marks a set whose tag and block were loaded
    logic                        sh_valid [2][SETS];
    logic                        sh_dirty [2][SETS];
    logic                        sh_known [2][SETS];
    logic [`CACHE_TAG_WIDTH-1:0] sh_tag   [2][SETS];
    cache_block_t                sh_block [2][SETS];
    logic                        sh_victim;
    logic                        victim_next;

    // expected responses for the current access
    cache_addr_fields_t           a;
    logic [1:0]                   match;
    logic                         exp_hit;
    logic                         exp_valid;
    logic                         exp_dirty;
    logic                         exp_known;
    logic                         exp_word_known;
    logic [`CACHE_WORD_WIDTH-1:0] exp_word;
    logic [`CACHE_TAG_WIDTH-1:0]  exp_tag;
    cache_block_t                 exp_block;

    function automatic logic [`CACHE_WORD_WIDTH-1:0] merge_bytes(
        input logic [`CACHE_WORD_WIDTH-1:0] old_word,
        input logic [`CACHE_WORD_WIDTH-1:0] new_word,
        input logic [3:0]                   be
    );
        logic [`CACHE_WORD_WIDTH-1:0] w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // expected values
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        a         = addr.fields;
        match[0]  = sh_valid[0][a.index] && (sh_tag[0][a.index] == a.tag);
        match[1]  = sh_valid[1][a.index] && (sh_tag[1][a.index] == a.tag);
        exp_hit   = enable && (match != 2'b00);
        exp_valid = enable && (sh_valid[0][a.index] || sh_valid[1][a.index]);
        exp_dirty = sh_dirty[0][a.index] && sh_dirty[1][a.index];
        // way 1's word whenever way 0 misses
        exp_word  = match[0] ? sh_block[0][a.index][a.word_sel]
                             : sh_block[1][a.index][a.word_sel];
        exp_word_known = match[0] || sh_known[1][a.index];
        exp_tag   = sh_tag[sh_victim][a.index];
        exp_block = sh_block[sh_victim][a.index];
        exp_known = sh_known[sh_victim][a.index];
        // an empty way goes first and then a clean one
        // with both ways dirty the victim alternates
        if (!sh_valid[0][a.index]) begin
            victim_next = 1'b0;
        end else if (!sh_valid[1][a.index]) begin
            victim_next = 1'b1;
        end else if (!sh_dirty[0][a.index]) begin
            victim_next = 1'b0;
        end else if (!sh_dirty[1][a.index]) begin
            victim_next = 1'b1;
        end else begin
            victim_next = ~sh_victim;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // shadow update
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < 2; w++) begin
                    sh_valid[w][s] <= 1'b0;
                    sh_dirty[w][s] <= 1'b0;
                    sh_known[w][s] <= 1'b0;
                end
            end
            sh_victim <= 1'b0;
        end else begin
            // block load goes to the victim whatever enable says
            if (write && !cmp) begin
                sh_tag[sh_victim][a.index]   <= a.tag;
                sh_block[sh_victim][a.index] <= data_block_in;
                sh_valid[sh_victim][a.index] <= valid_in;
                sh_dirty[sh_victim][a.index] <= 1'b0;
                sh_known[sh_victim][a.index] <= 1'b1;
            end
            for (int w = 0; w < 2; w++) begin
                if (write && cmp && enable && match[w]) begin
                    sh_block[w][a.index][a.word_sel] <= merge_bytes(
                        sh_block[w][a.index][a.word_sel], data_in, byte_w_en);
                    sh_dirty[w][a.index] <= 1'b1;
                end
            end
            if (enable && cmp) begin
                sh_victim <= victim_next;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    hit_chk: assert property (@(posedge clk) disable iff (!arst_n) hit == exp_hit)
        else begin
            assert_fail = 1'b1;
            $error("MISMATCH at %0t: hit is %b, expected %b", $time, hit, exp_hit);
        end

    valid_chk: assert property (@(posedge clk) disable iff (!arst_n) valid_out == exp_valid)
        else begin
            assert_fail = 1'b1;
            $error("MISMATCH at %0t: valid_out is %b, expected %b", $time, valid_out, exp_valid);
        end

    dirty_chk: assert property (@(posedge clk) disable iff (!arst_n) dirty == exp_dirty)
        else begin
            assert_fail = 1'b1;
            $error("MISMATCH at %0t: dirty is %b, expected %b", $time, dirty, exp_dirty);
        end

    word_chk: assert property (@(posedge clk) disable iff (!arst_n)
        !exp_word_known || (data_out == exp_word))
        else begin
            assert_fail = 1'b1;
            $error("MISMATCH at %0t: data_out is %h, expected %h", $time, data_out, exp_word);
        end

    // zero on compares and the victim's tag and block on loads
    wb_chk: assert property (@(posedge clk) disable iff (!arst_n)
        cmp ? (tag_out == '0 && data_wb == '0)
            : (!exp_known || (tag_out == exp_tag && data_wb == exp_block)))
        else begin
            assert_fail = 1'b1;
            $error("MISMATCH at %0t: write-back tag %h or block differs from victim tag %h",
                   $time, tag_out, exp_tag);
        end

endmodule

// File: verification/cache_2ways_tb.sv
`include "cache_macros.svh"

module cache_2ways_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import cache_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int N_OPS        = 600;
    // at most two cycles per random op, directed part below 100 cycles
    localparam int MAX_CYCLES   = 2 * (RESET_CYCLES + 100 + 2 * N_OPS);

    localparam logic [`CACHE_TAG_WIDTH-1:0]   TAG_A = 21'h0_1234;
    localparam logic [`CACHE_TAG_WIDTH-1:0]   TAG_B = 21'h1_5678;
    localparam logic [`CACHE_TAG_WIDTH-1:0]   TAG_C = 21'h0_9abc;
    localparam logic [`CACHE_INDEX_WIDTH-1:0] SET   = 6'd5;

    logic                         clk;
    logic                         arst_n;
    logic                         enable;
    logic                         cmp;
    logic                         write;
    logic [3:0]                   byte_w_en;
    logic                         valid_in;
    cache_addr_u                  addr;
    logic [`CACHE_WORD_WIDTH-1:0] data_in;
    cache_block_t                 data_block_in;
    logic                         hit;
    logic                         dirty;
    logic                         valid_out;
    logic [`CACHE_TAG_WIDTH-1:0]  tag_out;
    logic [`CACHE_WORD_WIDTH-1:0] data_out;
    cache_block_t                 data_wb;

    integer                        seed;
    logic                          last_hit;
    logic [`CACHE_TAG_WIDTH-1:0]   tag_pool [4];
    logic [`CACHE_INDEX_WIDTH-1:0] idx_pool [4];

    cache_2ways dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .enable        (enable),
        .cmp           (cmp),
        .write         (write),
        .byte_w_en     (byte_w_en),
        .valid_in      (valid_in),
        .addr          (addr),
        .data_in       (data_in),
        .data_block_in (data_block_in),
        .hit           (hit),
        .dirty         (dirty),
        .valid_out     (valid_out),
        .tag_out       (tag_out),
        .data_out      (data_out),
        .data_wb       (data_wb)
    );

    bind cache_2ways cache_2ways_assertions chk_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .enable        (enable),
        .cmp           (cmp),
        .write         (write),
        .byte_w_en     (byte_w_en),
        .valid_in      (valid_in),
        .addr          (addr),
        .data_in       (data_in),
        .data_block_in (data_block_in),
        .hit           (hit),
        .dirty         (dirty),
        .valid_out     (valid_out),
        .tag_out       (tag_out),
        .data_out      (data_out),
        .data_wb       (data_wb)
    );

    always #2 clk = ~clk;

    // one access per cycle, random byte enables and data
    task automatic drive_cycle(input logic en, input logic c, input logic wr, input logic vin,
                               input logic [`CACHE_TAG_WIDTH-1:0]    tag,
                               input logic [`CACHE_INDEX_WIDTH-1:0]  idx,
                               input logic [`CACHE_OFFSET_WIDTH-1:0] ws);
        logic [31:0] rnd;
        @(negedge clk);
        enable    = en;
        cmp       = c;
        write     = wr;
        valid_in  = vin;
        addr.raw  = {tag, idx, ws};
        rnd       = $random(seed);
        byte_w_en = rnd[3:0];
        data_in   = $random(seed);
        for (int i = 0; i < `CACHE_WORDS_PER_BLOCK; i++) begin
            data_block_in[i] = $random(seed);
        end
        #1;
        last_hit = hit;
    endtask

    // compare read, then a block load on a miss
    task automatic read_or_fill(input logic [`CACHE_TAG_WIDTH-1:0]    tag,
                                input logic [`CACHE_INDEX_WIDTH-1:0]  idx,
                                input logic [`CACHE_OFFSET_WIDTH-1:0] ws,
                                input logic                           vin);
        drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, tag, idx, ws);
        if (!last_hit) begin
            drive_cycle(1'b1, 1'b0, 1'b1, vin, tag, idx, ws);
        end
    endtask

    initial begin
        wait (dut_i.chk_i.assert_fail);
        $display("Testbench failed");
        $fatal(1, "an assertion in the checker reported a wrong value");
    end

    initial begin
        repeat (MAX_CYCLES) @(posedge clk);
        $display("Testbench failed");
        $fatal(1, "run timed out after %0d cycles", MAX_CYCLES);
    end

    initial begin
        logic [31:0] rnd;
        clk           = 1'b0;
        arst_n        = 1'b0;
        enable        = 1'b0;
        cmp           = 1'b0;
        write         = 1'b0;
        byte_w_en     = 4'd0;
        valid_in      = 1'b0;
        addr          = '0;
        data_in       = '0;
        data_block_in = '0;
        last_hit      = 1'b0;
        seed          = 64767;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // empty cache, nothing hits
        for (int n = 0; n < 16; n++) begin
            rnd = $random(seed);
            drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, rnd[20:0], rnd[26:21], rnd[29:27]);
        end

        ///////////////////////////////////////////////////////////////////
        // directed fills and victim choice in one set
        ///////////////////////////////////////////////////////////////////
        read_or_fill(TAG_A, SET, 3'd2, 1'b1);
        drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, TAG_A, SET, 3'd2);
        read_or_fill(TAG_B, SET, 3'd6, 1'b1);
        drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, TAG_B, SET, 3'd6);
        // way 0 dirty, so the clean way 1 goes next
        drive_cycle(1'b1, 1'b1, 1'b1, 1'b0, TAG_A, SET, 3'd3);
        drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, TAG_A, SET, 3'd3);
        read_or_fill(TAG_C, SET, 3'd1, 1'b1);
        drive_cycle(1'b1, 1'b1, 1'b1, 1'b0, TAG_C, SET, 3'd1);
        // both dirty, each compare flips the victim
        for (int n = 0; n < 4; n++) begin
            drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, TAG_A, SET, 3'd0);
            drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, TAG_A, SET, 3'd0);
        end

        ///////////////////////////////////////////////////////////////////
        // random mixed traffic over a few sets
        ///////////////////////////////////////////////////////////////////
        for (int i = 0; i < 4; i++) begin
            rnd         = $random(seed);
            tag_pool[i] = rnd[20:0];
            idx_pool[i] = rnd[26:21];
        end
        for (int n = 0; n < N_OPS; n++) begin
            rnd = $random(seed);
            case (rnd[9:7])
                3'd0, 3'd1: drive_cycle(1'b1, 1'b1, 1'b0, 1'b0, tag_pool[rnd[1:0]],
                                        idx_pool[rnd[3:2]], rnd[6:4]);
                3'd2, 3'd3: drive_cycle(1'b1, 1'b1, 1'b1, 1'b0, tag_pool[rnd[1:0]],
                                        idx_pool[rnd[3:2]], rnd[6:4]);
                3'd4, 3'd5: read_or_fill(tag_pool[rnd[1:0]], idx_pool[rnd[3:2]], rnd[6:4],
                                         rnd[13:10] != 4'd0);
                3'd6: drive_cycle(1'b1, 1'b0, 1'b0, 1'b0, tag_pool[rnd[1:0]],
                                  idx_pool[rnd[3:2]], rnd[6:4]);
                default: drive_cycle(1'b0, 1'b1, rnd[10], 1'b0, tag_pool[rnd[1:0]],
                                     idx_pool[rnd[3:2]], rnd[6:4]);
            endcase
        end

        drive_cycle(1'b0, 1'b1, 1'b0, 1'b0, TAG_A, SET, 3'd0);
        @(negedge clk);
        if (dut_i.chk_i.assert_fail) begin
            $display("Testbench failed");
            $fatal(1, "an assertion in the checker reported a wrong value");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+include
logic/cache_pkg.sv
logic/cache_oneline.sv
logic/victimway_sel.sv
logic/cache_2ways.sv
verification/cache_2ways_assertions.sv
verification/cache_2ways_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps \
        -f vlog.f --top-module cache_2ways_tb \
    && ./obj_dir/Vcache_2ways_tb +verilator+error+limit+100 \
    || exit 1
